// File: tb.f
+incdir+verification
verilog/axi_bridge_pkg.sv
verilog/read_arbiter.sv
verilog/line_read_engine.sv
verilog/line_write_engine.sv
verilog/axi_bridge_top.sv
verification/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of tb_top, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_top -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^Test OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/tb_tasks.svh
// values up to one full line wide
task automatic compare(input string name, input line_t expected, input line_t actual);
    if (actual !== expected) begin
        mismatches++;
        $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

function automatic logic rdy_of(input int which);
    case (which)
        0:       rdy_of = icache_rd_rdy;
        1:       rdy_of = dcache_rd_rdy;
        default: rdy_of = dcache_wr_rdy;  // writeback
    endcase
endfunction

// returns on an edge where the requester is idle
task automatic wait_ready(input int which);
    int n;
    n = 0;
    @(posedge clk);
    while (!rdy_of(which) && n < TIMEOUT) begin
        @(posedge clk);
        n++;
    end
    if (!rdy_of(which)) begin
        failures++;
        $display("timeout at %0t ns: requester %0d stayed busy", $time, which);
    end
endtask

task automatic wait_refills(input logic want_i, input logic want_d);
    int   n;
    logic got_i;
    logic got_d;
    n     = 0;
    got_i = !want_i;
    got_d = !want_d;
    while (!(got_i && got_d) && n < TIMEOUT) begin
        @(posedge clk);
        got_i = got_i || icache_ret_valid;
        got_d = got_d || dcache_ret_valid;
        n++;
    end
    if (!(got_i && got_d)) begin
        failures++;
        $display("timeout at %0t ns: a refill never returned its line", $time);
    end
endtask

task automatic start_reads(input logic do_i, input addr_t ai, input logic do_d, input addr_t ad);
    if (do_i) wait_ready(0);
    if (do_d) wait_ready(1);
    icache_rd_req  <= do_i;
    icache_rd_addr <= ai;
    dcache_rd_req  <= do_d;
    dcache_rd_addr <= ad;
    @(posedge clk);
    icache_rd_req  <= 1'b0;
    dcache_rd_req  <= 1'b0;
    icache_rd_addr <= 32'hdead_beef;  // engine holds its own copy now
    dcache_rd_addr <= 32'hdead_beef;
endtask

task automatic write_line(input addr_t a, input line_t l);
    wait_ready(2);
    dcache_wr_req  <= 1'b1;
    dcache_wr_addr <= a;
    dcache_wr_data <= l;
    @(posedge clk);
    dcache_wr_req  <= 1'b0;
    dcache_wr_addr <= 32'hdead_beef;  // address and line already captured
    dcache_wr_data <= ~l;
    wait_ready(2);  // rdy back after the B handshake
endtask

task automatic test_reset();
    compare("arvalid", '0, line_t'(arvalid));
    compare("awvalid", '0, line_t'(awvalid));
    compare("wvalid", '0, line_t'(wvalid));
    compare("rready", '0, line_t'(rready));
    compare("bready", '0, line_t'(bready));
    compare("icache_ret_valid", '0, line_t'(icache_ret_valid));
    compare("dcache_ret_valid", '0, line_t'(dcache_ret_valid));
    compare("icache_rd_rdy", line_t'(1'b1), line_t'(icache_rd_rdy));
    compare("dcache_rd_rdy", line_t'(1'b1), line_t'(dcache_rd_rdy));
    compare("dcache_wr_rdy", line_t'(1'b1), line_t'(dcache_wr_rdy));
endtask

// first_id names the requester whose AR must reach the port first
task automatic test_refills(input logic do_i, input addr_t ai, input logic do_d,
                            input addr_t ad, input axi_id_t first_id);
    int    first;
    line_t exp_i;
    line_t exp_d;
    first = ar_seen.size();
    exp_i = mem_line(ai);
    exp_d = mem_line(ad);
    start_reads(do_i, ai, do_d, ad);
    wait_refills(do_i, do_d);
    if (do_i) compare("icache_ret_data", exp_i, icache_ret_data);
    if (do_d) compare("dcache_ret_data", exp_d, dcache_ret_data);
    if (ar_seen.size() <= first) begin
        failures++;
        $display("no AR handshake seen at the port for this refill");
    end else begin
        compare("ar.id", line_t'(first_id), line_t'(ar_seen[first].id));
        compare("ar.addr", line_t'(first_id == DCACHE_ID ? ad : ai),
                line_t'(ar_seen[first].addr));
    end
endtask

task automatic test_writeback_refill(input addr_t a, input line_t l);
    write_line(a, l);
    test_refills(1'b0, '0, 1'b1, a, DCACHE_ID);
    compare("dcache_ret_data after writeback", l, dcache_ret_data);
endtask

// File: verification/tb_top.sv
`timescale 1ns/1ns

module tb_top;
    import axi_bridge_pkg::*;

    localparam axi_id_t ICACHE_ID = 4'd3;
    localparam axi_id_t DCACHE_ID = 4'd9;
    localparam int      TIMEOUT   = 2000;  // cycles allowed per wait

    logic       clk;
    logic       resetn;
    axi_ar_t    ar;
    axi_r_t     r = '0;
    axi_aw_t    aw;
    axi_w_t     w;
    logic       arvalid, rready, awvalid, wvalid, bready;
    logic       arready = 1'b0, rvalid = 1'b0, awready = 1'b0, wready = 1'b0, bvalid = 1'b0;
    logic [1:0] bresp = 2'b00;
    logic       icache_rd_req, dcache_rd_req, dcache_wr_req;
    addr_t      icache_rd_addr, dcache_rd_addr, dcache_wr_addr;
    line_t      dcache_wr_data, icache_ret_data, dcache_ret_data;
    logic       icache_rd_rdy, dcache_rd_rdy, dcache_wr_rdy;
    logic       icache_ret_valid, dcache_ret_valid;

    word_t      mem [256];
    axi_ar_t    ar_q[$];      // accepted, still to be answered
    axi_ar_t    ar_seen[$];   // every AR handshake at the port
    int         r_beat, w_beat;
    addr_t      aw_addr;
    logic       b_pend;
    logic       stall = 1'b0;
    integer     seed = 1102;
    int         mismatches = 0, failures = 0;
    logic       ar_stalled = 1'b0, aw_stalled = 1'b0;
    axi_ar_t    ar_prev;
    axi_aw_t    aw_prev;

    `include "tb_tasks.svh"

    axi_bridge_top #(.ICACHE_ID(ICACHE_ID), .DCACHE_ID(DCACHE_ID)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [7:0] word_index(input addr_t a, input int beat);
        word_index = a[9:2] + 8'(beat);  // wraps inside the 1 KB window
    endfunction

    function automatic line_t mem_line(input addr_t a);
        line_t l;
        for (int k = 0; k < BEATS; k++) begin
            l[k*DATA_W +: DATA_W] = mem[word_index(a, k)];
        end
        return l;
    endfunction

    function automatic logic hold_off();
        hold_off = stall && (($random(seed) & 1) != 0);  // about half the time
    endfunction

    // AXI slave memory, in-order answers
    always @(posedge clk) begin
        if (!resetn) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            ar_q.delete();
            r_beat = 0;
            w_beat = 0;
            b_pend = 1'b0;
            for (int i = 0; i < 256; i++) begin
                mem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i * 7)};
            end
        end else begin
            if (arvalid && arready) begin
                ar_q.push_back(ar);
                ar_seen.push_back(ar);
            end
            arready <= !hold_off();
            // one beat, then at least one idle cycle
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                if (r_beat == BEATS - 1) begin
                    ar_q.delete(0);
                    r_beat = 0;
                end else begin
                    r_beat = r_beat + 1;
                end
            end else if (!rvalid && ar_q.size() != 0 && !hold_off()) begin
                rvalid <= 1'b1;
                r      <= '{id: ar_q[0].id, data: mem[word_index(ar_q[0].addr, r_beat)],
                            resp: 2'b00, last: r_beat == BEATS - 1};
            end
            if (awvalid && awready) begin
                aw_addr = aw.addr;
                w_beat  = 0;
            end
            awready <= !hold_off();
            if (wvalid && wready) begin
                compare("w.strb", line_t'(4'hf), line_t'(w.strb));
                compare("w.last", line_t'(w_beat == BEATS - 1), line_t'(w.last));
                mem[word_index(aw_addr, w_beat)] = w.data;
                b_pend = b_pend || (w_beat == BEATS - 1);
                w_beat = w_beat + 1;
            end
            wready <= !hold_off();
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (b_pend && !bvalid && !hold_off()) begin
                bvalid <= 1'b1;
                b_pend = 1'b0;
            end
        end
        // address payload must not move while stalled
        if (ar_stalled) begin
            compare("arvalid", line_t'(1'b1), line_t'(arvalid));
            compare("ar", line_t'(ar_prev), line_t'(ar));
        end
        if (aw_stalled) begin
            compare("awvalid", line_t'(1'b1), line_t'(awvalid));
            compare("aw", line_t'(aw_prev), line_t'(aw));
        end
        ar_stalled = resetn && arvalid && !arready;
        aw_stalled = resetn && awvalid && !awready;
        ar_prev    = ar;
        aw_prev    = aw;
    end

    initial begin
        addr_t a;
        line_t l;
        icache_rd_req  = 1'b0;
        dcache_rd_req  = 1'b0;
        dcache_wr_req  = 1'b0;
        icache_rd_addr = '0;
        dcache_rd_addr = '0;
        dcache_wr_addr = '0;
        dcache_wr_data = '0;
        resetn         = 1'b0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        test_reset();
        test_refills(1'b1, 32'h0000_0040, 1'b0, '0, ICACHE_ID);
        test_writeback_refill(32'h0000_0100, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
        test_refills(1'b1, 32'h0000_0200, 1'b1, 32'h0000_0300, DCACHE_ID);
        stall <= 1'b1;
        repeat (8) begin
            a = addr_t'($random(seed)) & 32'h0000_03f0;
            l = {$random(seed), $random(seed), $random(seed), $random(seed)};
            test_writeback_refill(a, l);
            a = addr_t'($random(seed)) & 32'h0000_03f0;
            test_refills(1'b1, a, 1'b1, a ^ 32'h0000_0200, DCACHE_ID);
        end
        $display("mismatches: %0d, other errors: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/axi_bridge_top.sv
`timescale 1ns/1ns

module axi_bridge_top #(
    parameter axi_bridge_pkg::axi_id_t ICACHE_ID = 4'd0,
    parameter axi_bridge_pkg::axi_id_t DCACHE_ID = 4'd1
) (
    input  logic                    clk,
    input  logic                    resetn,
    // external AXI port
    output axi_bridge_pkg::axi_ar_t ar,
    output logic                    arvalid,
    input  logic                    arready,
    input  axi_bridge_pkg::axi_r_t  r,
    input  logic                    rvalid,
    output logic                    rready,
    output axi_bridge_pkg::axi_aw_t aw,
    output logic                    awvalid,
    input  logic                    awready,
    output axi_bridge_pkg::axi_w_t  w,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic [1:0]              bresp,     // not checked by the write engine
    input  logic                    bvalid,
    output logic                    bready,
    // icache refill
    input  logic                    icache_rd_req,
    input  axi_bridge_pkg::addr_t   icache_rd_addr,
    output logic                    icache_rd_rdy,
    output logic                    icache_ret_valid,
    output axi_bridge_pkg::line_t   icache_ret_data,
    // dcache refill
    input  logic                    dcache_rd_req,
    input  axi_bridge_pkg::addr_t   dcache_rd_addr,
    output logic                    dcache_rd_rdy,
    output logic                    dcache_ret_valid,
    output axi_bridge_pkg::line_t   dcache_ret_data,
    // dcache writeback
    input  logic                    dcache_wr_req,
    input  axi_bridge_pkg::addr_t   dcache_wr_addr,
    input  axi_bridge_pkg::line_t   dcache_wr_data,
    output logic                    dcache_wr_rdy
);
    import axi_bridge_pkg::*;

    axi_ar_t i_ar, d_ar;
    logic    i_arvalid, i_arready, d_arvalid, d_arready;
    axi_r_t  i_r, d_r;
    logic    i_rvalid, i_rready, d_rvalid, d_rready;

    line_read_engine #(.rd_id(ICACHE_ID)) u_iread (
        .clk(clk), .resetn(resetn),
        .rd_req(icache_rd_req), .rd_addr(icache_rd_addr), .rd_rdy(icache_rd_rdy),
        .ret_valid(icache_ret_valid), .ret_data(icache_ret_data),
        .ar(i_ar), .arvalid(i_arvalid), .arready(i_arready),
        .r(i_r), .rvalid(i_rvalid), .rready(i_rready)
    );

    line_read_engine #(.rd_id(DCACHE_ID)) u_dread (
        .clk(clk), .resetn(resetn),
        .rd_req(dcache_rd_req), .rd_addr(dcache_rd_addr), .rd_rdy(dcache_rd_rdy),
        .ret_valid(dcache_ret_valid), .ret_data(dcache_ret_data),
        .ar(d_ar), .arvalid(d_arvalid), .arready(d_arready),
        .r(d_r), .rvalid(d_rvalid), .rready(d_rready)
    );

    read_arbiter #(.icache_id(ICACHE_ID), .dcache_id(DCACHE_ID)) u_rd_arb (
        .clk(clk), .resetn(resetn),
        .i_ar(i_ar), .i_arvalid(i_arvalid), .i_arready(i_arready),
        .d_ar(d_ar), .d_arvalid(d_arvalid), .d_arready(d_arready),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready),
        .i_r(i_r), .i_rvalid(i_rvalid), .i_rready(i_rready),
        .d_r(d_r), .d_rvalid(d_rvalid), .d_rready(d_rready)
    );

    // writeback has the write channels to itself
    line_write_engine u_dwrite (
        .clk(clk), .resetn(resetn),
        .wr_req(dcache_wr_req), .wr_addr(dcache_wr_addr), .wr_data(dcache_wr_data),
        .wr_rdy(dcache_wr_rdy),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

endmodule

// File: verilog/line_write_engine.sv
`timescale 1ns/1ns

module line_write_engine (
    input  logic                    clk,
    input  logic                    resetn,
    // cache side
    input  logic                    wr_req,
    input  axi_bridge_pkg::addr_t   wr_addr,
    input  axi_bridge_pkg::line_t   wr_data,
    output logic                    wr_rdy,
    // write address
    output axi_bridge_pkg::axi_aw_t aw,
    output logic                    awvalid,
    input  logic                    awready,
    // write data
    output axi_bridge_pkg::axi_w_t  w,
    output logic                    wvalid,
    input  logic                    wready,
    // write response
    input  logic                    bvalid,
    output logic                    bready
);
    import axi_bridge_pkg::*;

    wr_state_e state;
    beat_cnt_t beat_cnt;
    addr_t     addr_q;
    line_t     line_q;
    logic      last_beat;
    logic      beat_hs;

    assign last_beat = (beat_cnt == beat_cnt_t'(BEATS - 1));
    assign beat_hs   = wvalid && wready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= WR_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (wr_req) begin
                        state <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (awready) begin
                        state    <= WR_DATA;
                        beat_cnt <= '0;
                    end
                end
                WR_DATA: begin
                    if (beat_hs) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    // response code not checked
                    if (bvalid) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // address and line captured at acceptance
    always_ff @(posedge clk) begin
        if (state == WR_IDLE && wr_req) begin
            addr_q <= wr_addr;
            line_q <= wr_data;
        end
    end

    assign wr_rdy  = (state == WR_IDLE);
    assign awvalid = (state == WR_ADDR);
    assign wvalid  = (state == WR_DATA);
    assign bready  = (state == WR_RESP);

    assign aw = '{addr: addr_q};

    // word 0 goes out first
    always_comb begin
        w.data = line_q[beat_cnt*DATA_W +: DATA_W];
        w.strb = '1;         // full lines only
        w.last = last_beat;
    end

endmodule

// File: verilog/line_read_engine.sv
`timescale 1ns/1ns

module line_read_engine #(
    parameter axi_bridge_pkg::axi_id_t rd_id = '0
) (
    input  logic                    clk,
    input  logic                    resetn,
    // cache side
    input  logic                    rd_req,
    input  axi_bridge_pkg::addr_t   rd_addr,
    output logic                    rd_rdy,
    output logic                    ret_valid,
    output axi_bridge_pkg::line_t   ret_data,
    // read address toward the arbiter
    output axi_bridge_pkg::axi_ar_t ar,
    output logic                    arvalid,
    input  logic                    arready,
    // read data, already steered by id
    input  axi_bridge_pkg::axi_r_t  r,
    input  logic                    rvalid,
    output logic                    rready
);
    import axi_bridge_pkg::*;

    rd_state_e state;
    beat_cnt_t beat_cnt;
    addr_t     addr_q;
    line_t     fill_q;     // words collected so far
    line_t     fill_line;  // fill_q with the current beat merged in
    logic      beat_hs;

    assign beat_hs = rvalid && rready;

    always_comb begin
        fill_line = fill_q;
        fill_line[beat_cnt*DATA_W +: DATA_W] = r.data;  // beat k -> word k
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= RD_IDLE;
            beat_cnt  <= '0;
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (rd_req) begin
                        state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arready) begin
                        state    <= RD_DATA;
                        beat_cnt <= '0;
                    end
                end
                RD_DATA: begin
                    if (beat_hs) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r.last) begin
                            state     <= RD_IDLE;
                            ret_valid <= 1'b1;  // one cycle, line already in ret_data
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // payload, only qualified by the control state above
    always_ff @(posedge clk) begin
        if (state == RD_IDLE && rd_req) begin
            addr_q <= rd_addr;
        end
        if (state == RD_DATA && beat_hs) begin
            fill_q <= fill_line;
            if (r.last) begin
                ret_data <= fill_line;  // held until the next refill ends
            end
        end
    end

    assign rd_rdy  = (state == RD_IDLE);
    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_DATA);
    assign ar      = '{id: rd_id, addr: addr_q};

endmodule

// File: verilog/read_arbiter.sv
`timescale 1ns/1ns

module read_arbiter #(
    parameter axi_bridge_pkg::axi_id_t icache_id = 4'd0,
    parameter axi_bridge_pkg::axi_id_t dcache_id = 4'd1
) (
    input  logic                    clk,
    input  logic                    resetn,
    // requests from the two refill engines
    input  axi_bridge_pkg::axi_ar_t i_ar,
    input  logic                    i_arvalid,
    output logic                    i_arready,
    input  axi_bridge_pkg::axi_ar_t d_ar,
    input  logic                    d_arvalid,
    output logic                    d_arready,
    // external read address
    output axi_bridge_pkg::axi_ar_t ar,
    output logic                    arvalid,
    input  logic                    arready,
    // external read data
    input  axi_bridge_pkg::axi_r_t  r,
    input  logic                    rvalid,
    output logic                    rready,
    // read data back to the engines
    output axi_bridge_pkg::axi_r_t  i_r,
    output logic                    i_rvalid,
    input  logic                    i_rready,
    output axi_bridge_pkg::axi_r_t  d_r,
    output logic                    d_rvalid,
    input  logic                    d_rready
);
    import axi_bridge_pkg::*;

    logic gnt_held;   // a request is stalled waiting for arready
    logic gnt_d_q;    // owner of the held grant, 1 = dcache
    logic sel_d;
    logic to_i;
    logic to_d;

    // dcache wins when nothing is held
    assign sel_d = gnt_held ? gnt_d_q : d_arvalid;

    assign ar        = sel_d ? d_ar : i_ar;
    assign arvalid   = sel_d ? d_arvalid : i_arvalid;
    assign d_arready = sel_d && arready;
    assign i_arready = !sel_d && arready;

    // keep the winner until its address is taken
    always_ff @(posedge clk) begin
        if (!resetn) begin
            gnt_held <= 1'b0;
            gnt_d_q  <= 1'b0;
        end else begin
            gnt_held <= arvalid && !arready;
            gnt_d_q  <= sel_d;
        end
    end

    // read data steering by id
    assign to_i = (r.id == icache_id);
    assign to_d = (r.id == dcache_id);

    assign i_r      = r;
    assign d_r      = r;
    assign i_rvalid = rvalid && to_i;
    assign d_rvalid = rvalid && to_d;

    always_comb begin
        if (to_d) begin
            rready = d_rready;
        end else if (to_i) begin
            rready = i_rready;
        end else begin
            rready = 1'b0;  // unknown id, nobody takes it
        end
    end

endmodule

// File: verilog/axi_bridge_pkg.sv
package axi_bridge_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BEATS  = 4;                 // beats per cache line
    localparam int LINE_W = BEATS * DATA_W;    // 128
    localparam int ID_W   = 4;

    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic [DATA_W-1:0]        word_t;
    typedef logic [LINE_W-1:0]        line_t;  // word 0 in the low bits
    typedef logic [ID_W-1:0]          axi_id_t;
    typedef logic [$clog2(BEATS)-1:0] beat_cnt_t;

    // read address channel
    typedef struct packed {
        axi_id_t id;
        addr_t   addr;
    } axi_ar_t;

    // read data channel
    typedef struct packed {
        axi_id_t    id;
        word_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    // write address, burst shape is fixed so only the address travels
    typedef struct packed {
        addr_t addr;
    } axi_aw_t;

    typedef struct packed {
        word_t                 data;
        logic [DATA_W/8-1:0]   strb;
        logic                  last;
    } axi_w_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

endpackage
